//--- Makefile
# Verilator build and run for the analog top level testbench

VERILATOR ?= verilator
TOP       ?= tb_rp_analog_top
FILELIST  ?= rp_analog_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/adc_frontend.sv
////////////////////////////////////////////////////////////////////////////
// ADC front end
// pin register, neg-slope to two's complement, loopback select, calibration
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module adc_frontend (
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  input  rp_pkg::dac_word_t                       adc_dat_a_i,
  input  rp_pkg::dac_word_t                       adc_dat_b_i,
  input  rp_pkg::sample_t  [rp_pkg::NUM_CHN-1:0] loop_dat_i,     // calibrated DAC data
  input  logic                                    digital_loop_i,
  input  rp_pkg::cal_cfg_t [rp_pkg::NUM_CHN-1:0] cfg_i,
  output rp_pkg::sample_t  [rp_pkg::NUM_CHN-1:0] adc_dat_o
);

  import rp_pkg::*;

  dac_word_t [NUM_CHN-1:0] pin_dat;
  sample_t   [NUM_CHN-1:0] raw_q;    // registered, already two's complement
  sample_t   [NUM_CHN-1:0] mux_dat;

  assign pin_dat = {adc_dat_b_i, adc_dat_a_i};  // channel 0 is A

  // input register, sign bit kept, lower bits inverted
  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
      raw_q <= '0;
    else
    begin
      for (int i = 0; i < NUM_CHN; i++)
        raw_q[i] <= {pin_dat[i][ADC_DW-1], ~pin_dat[i][ADC_DW-2:0]};
    end
  end

  for (genvar i = 0; i < NUM_CHN; i++)
  begin : g_chn
    // loopback bypasses the pin register, 2+2 cycles DAC to ADC
    assign mux_dat[i] = digital_loop_i ? loop_dat_i[i] : raw_q[i];

    linear_cal u_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (mux_dat[i]),
      .cfg_i   (cfg_i[i]),
      .dat_o   (adc_dat_o[i])
    );
  end

endmodule

//--- hw/calib_regs.sv
////////////////////////////////////////////////////////////////////////////
// calibration registers
// gain and offset per ADC and DAC channel
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module calib_regs (
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  input  rp_pkg::sys_req_t                        bus_req_i,  // gated to region 1
  output rp_pkg::sys_rsp_t                        bus_rsp_o,
  output rp_pkg::cal_cfg_t [rp_pkg::NUM_CHN-1:0] adc_cfg_o,
  output rp_pkg::cal_cfg_t [rp_pkg::NUM_CHN-1:0] dac_cfg_o
);

  import rp_pkg::*;

  logic [7:0]        reg_ofs;
  logic [SYS_DW-1:0] rd_dat;

  assign reg_ofs = bus_req_i.addr[7:0];  // upper address bits ignored

  ////////////////////////////////////////////////////////////////////////////
  // register writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
    begin
      for (int i = 0; i < NUM_CHN; i++)
      begin
        adc_cfg_o[i].mul <= CAL_UNITY;  // unity gain, no offset
        adc_cfg_o[i].sum <= '0;
        dac_cfg_o[i].mul <= CAL_UNITY;
        dac_cfg_o[i].sum <= '0;
      end
    end
    else if (bus_req_i.wen)
    begin
      for (int i = 0; i < NUM_CHN; i++)
      begin
        // gain from wdata[15:0], offset from wdata[13:0]
        if (reg_ofs == 8'(CAL_ADC_BASE + CAL_CHN_STEP*i))
          adc_cfg_o[i].mul <= bus_req_i.wdata[CAL_MW-1:0];
        if (reg_ofs == 8'(CAL_ADC_BASE + CAL_CHN_STEP*i + CAL_SUM_OFS))
          adc_cfg_o[i].sum <= bus_req_i.wdata[ADC_DW-1:0];
        if (reg_ofs == 8'(CAL_DAC_BASE + CAL_CHN_STEP*i))
          dac_cfg_o[i].mul <= bus_req_i.wdata[CAL_MW-1:0];
        if (reg_ofs == 8'(CAL_DAC_BASE + CAL_CHN_STEP*i + CAL_SUM_OFS))
          dac_cfg_o[i].sum <= bus_req_i.wdata[ADC_DW-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback, sign extended to the bus width
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    rd_dat = '0;  // unmapped offsets
    for (int i = 0; i < NUM_CHN; i++)
    begin
      if (reg_ofs == 8'(CAL_ADC_BASE + CAL_CHN_STEP*i))
        rd_dat = {{(SYS_DW-CAL_MW){adc_cfg_o[i].mul[CAL_MW-1]}}, adc_cfg_o[i].mul};
      if (reg_ofs == 8'(CAL_ADC_BASE + CAL_CHN_STEP*i + CAL_SUM_OFS))
        rd_dat = {{(SYS_DW-ADC_DW){adc_cfg_o[i].sum[ADC_DW-1]}}, adc_cfg_o[i].sum};
      if (reg_ofs == 8'(CAL_DAC_BASE + CAL_CHN_STEP*i))
        rd_dat = {{(SYS_DW-CAL_MW){dac_cfg_o[i].mul[CAL_MW-1]}}, dac_cfg_o[i].mul};
      if (reg_ofs == 8'(CAL_DAC_BASE + CAL_CHN_STEP*i + CAL_SUM_OFS))
        rd_dat = {{(SYS_DW-ADC_DW){dac_cfg_o[i].sum[ADC_DW-1]}}, dac_cfg_o[i].sum};
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
      bus_rsp_o <= '0;
    else
    begin
      bus_rsp_o.ack   <= bus_req_i.wen | bus_req_i.ren;  // one cycle after strobe
      bus_rsp_o.err   <= 1'b0;
      bus_rsp_o.rdata <= bus_req_i.ren ? rd_dat : '0;
    end
  end

endmodule

//--- hw/dac_backend.sv
////////////////////////////////////////////////////////////////////////////
// DAC back end
// calibration and output register back to unsigned negative slope
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dac_backend (
  input  logic                                     adc_clk,
  input  logic                                     top_rst,
  input  rp_pkg::sample_t   [rp_pkg::NUM_CHN-1:0] dac_dat_i,
  input  rp_pkg::cal_cfg_t  [rp_pkg::NUM_CHN-1:0] cfg_i,
  output rp_pkg::sample_t   [rp_pkg::NUM_CHN-1:0] cal_dat_o,  // to ADC loopback
  output rp_pkg::dac_word_t [rp_pkg::NUM_CHN-1:0] dac_dat_o
);

  import rp_pkg::*;

  sample_t [NUM_CHN-1:0] out_q;  // output register, resets to 0

  for (genvar i = 0; i < NUM_CHN; i++)
  begin : g_chn
    linear_cal u_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (dac_dat_i[i]),
      .cfg_i   (cfg_i[i]),
      .dat_o   (cal_dat_o[i])
    );

    // back to pin format, 0 shows as 0x1fff
    assign dac_dat_o[i] = {out_q[i][ADC_DW-1], ~out_q[i][ADC_DW-2:0]};
  end

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
      out_q <= '0;
    else
      out_q <= cal_dat_o;  // third cycle of the DAC path
  end

endmodule

//--- hw/hk_regs.sv
////////////////////////////////////////////////////////////////////////////
// housekeeping registers
// ID, digital loopback enable and LEDs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module hk_regs (
  input  logic             adc_clk,
  input  logic             top_rst,
  input  rp_pkg::sys_req_t bus_req_i,  // strobes already gated to region 0
  output rp_pkg::sys_rsp_t bus_rsp_o,
  output logic             digital_loop_o,
  output logic [7:0]       led_o
);

  import rp_pkg::*;

  logic [7:0]        reg_ofs;  // only addr[7:0] decoded
  logic [SYS_DW-1:0] rd_dat;

  assign reg_ofs = bus_req_i.addr[7:0];

  // writes, full word, ID is read-only
  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end
    else if (bus_req_i.wen)
    begin
      if (reg_ofs == HK_LOOP_OFS) digital_loop_o <= bus_req_i.wdata[0];
      if (reg_ofs == HK_LED_OFS)  led_o          <= bus_req_i.wdata[7:0];
    end
  end

  // read mux, unmapped offsets read 0
  always_comb
  begin
    case (reg_ofs)
      HK_ID_OFS:   rd_dat = HK_ID;
      HK_LOOP_OFS: rd_dat = {{(SYS_DW-1){1'b0}}, digital_loop_o};
      HK_LED_OFS:  rd_dat = {{(SYS_DW-8){1'b0}}, led_o};
      default:     rd_dat = '0;
    endcase
  end

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
      bus_rsp_o <= '0;
    else
    begin
      bus_rsp_o.ack   <= bus_req_i.wen | bus_req_i.ren;
      bus_rsp_o.err   <= 1'b0;  // every offset is answered
      bus_rsp_o.rdata <= bus_req_i.ren ? rd_dat : '0;
    end
  end

endmodule

//--- hw/linear_cal.sv
////////////////////////////////////////////////////////////////////////////
// linear calibration, one channel
// dat*mul >>> 14 + sum, saturated to 14 bits, 2 cycle latency
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module linear_cal (
  input  logic             adc_clk,
  input  logic             top_rst,
  input  rp_pkg::sample_t  dat_i,
  input  rp_pkg::cal_cfg_t cfg_i,
  output rp_pkg::sample_t  dat_o
);

  import rp_pkg::*;

  logic signed [ADC_DW+CAL_MW-1:0]   prd_q;    // full product, Q2.14 scaled
  logic signed [ADC_DW+CAL_MW-CAL_FRAC:0] sum;  // one guard bit over the shifted product
  sample_t                           sat;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1, multiply
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
      prd_q <= '0;
    else
      prd_q <= dat_i * $signed(cfg_i.mul);
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2, shift, add offset, saturate
  ////////////////////////////////////////////////////////////////////////////

  // dropping the fraction bits is the arithmetic shift
  assign sum = $signed(prd_q[ADC_DW+CAL_MW-1:CAL_FRAC]) + $signed(cfg_i.sum);

  always_comb
  begin
    // bits above the sample sign must all match it, else clamp
    if (sum[ADC_DW+CAL_MW-CAL_FRAC:ADC_DW-1] != {(CAL_MW-CAL_FRAC+2){sum[ADC_DW+CAL_MW-CAL_FRAC]}})
      sat = {sum[ADC_DW+CAL_MW-CAL_FRAC], {(ADC_DW-1){~sum[ADC_DW+CAL_MW-CAL_FRAC]}}};
    else
      sat = sum[ADC_DW-1:0];
  end

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
      dat_o <= '0;
    else
      dat_o <= sat;  // 8191 .. -8192
  end

endmodule

//--- hw/rp_analog_top.sv
////////////////////////////////////////////////////////////////////////////
// analog top level
// ADC capture, DAC output, calibration and the register bus that sets them
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rp_analog_top (
  input  logic                                     adc_clk,
  input  logic                                     top_rst,
  // ADC pins, unsigned negative slope
  input  rp_pkg::dac_word_t                        adc_dat_a_i,
  input  rp_pkg::dac_word_t                        adc_dat_b_i,
  // DAC samples from the application side
  input  rp_pkg::sample_t   [rp_pkg::NUM_CHN-1:0] dac_dat_i,
  // system bus
  input  rp_pkg::sys_req_t                         sys_req_i,
  output rp_pkg::sys_rsp_t                         sys_rsp_o,
  // data outputs
  output rp_pkg::sample_t   [rp_pkg::NUM_CHN-1:0] adc_dat_o,
  output rp_pkg::dac_word_t [rp_pkg::NUM_CHN-1:0] dac_dat_o,
  output logic              [7:0]                  led_o
);

  import rp_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////////////////////

  sys_req_t hk_req;   // gated to region 0
  sys_rsp_t hk_rsp;
  sys_req_t cal_req;  // gated to region 1
  sys_rsp_t cal_rsp;

  logic digital_loop;

  cal_cfg_t [NUM_CHN-1:0] adc_cfg;
  cal_cfg_t [NUM_CHN-1:0] dac_cfg;
  sample_t  [NUM_CHN-1:0] dac_cal;  // calibrated DAC data, loopback source

  ////////////////////////////////////////////////////////////////////////////
  // bus decoder and register blocks
  ////////////////////////////////////////////////////////////////////////////

  sys_bus_decoder u_dec (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .hk_rsp_i  (hk_rsp),
    .cal_req_o (cal_req),
    .cal_rsp_i (cal_rsp)
  );

  hk_regs u_hk (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .bus_req_i      (hk_req),
    .bus_rsp_o      (hk_rsp),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  calib_regs u_calib (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .bus_req_i (cal_req),
    .bus_rsp_o (cal_rsp),
    .adc_cfg_o (adc_cfg),
    .dac_cfg_o (dac_cfg)
  );

  ////////////////////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend u_adc (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .loop_dat_i     (dac_cal),
    .digital_loop_i (digital_loop),
    .cfg_i          (adc_cfg),
    .adc_dat_o      (adc_dat_o)
  );

  dac_backend u_dac (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .dac_dat_i (dac_dat_i),
    .cfg_i     (dac_cfg),
    .cal_dat_o (dac_cal),
    .dac_dat_o (dac_dat_o)
  );

endmodule

//--- hw/rp_pkg.sv
////////////////////////////////////////////////////////////////////////////
// analog path package
// widths, bus and calibration types, register map constants
////////////////////////////////////////////////////////////////////////////

package rp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and counts
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NUM_CHN  = 2;   // analog channels
  localparam int unsigned ADC_DW   = 14;  // sample width
  localparam int unsigned CAL_MW   = 16;  // gain width
  localparam int unsigned CAL_FRAC = 14;  // gain fraction bits, Q2.14

  localparam logic [CAL_MW-1:0] CAL_UNITY = 16'd16384;  // gain 1.0

  // system bus geometry
  localparam int unsigned SYS_AW     = 32;
  localparam int unsigned SYS_DW     = 32;
  localparam int unsigned REGION_LSB = 20;  // region field is addr[22:20]
  localparam int unsigned REGION_W   = 3;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [SYS_DW-1:0] HK_ID = 32'h5250_0001;  // read-only

  localparam logic [7:0] HK_ID_OFS   = 8'h00;
  localparam logic [7:0] HK_LOOP_OFS = 8'h04;  // bit 0 = digital loopback
  localparam logic [7:0] HK_LED_OFS  = 8'h08;

  localparam logic [7:0] CAL_ADC_BASE = 8'h00;
  localparam logic [7:0] CAL_DAC_BASE = 8'h10;
  localparam int unsigned CAL_CHN_STEP = 8;  // gain word, then offset word
  localparam int unsigned CAL_SUM_OFS  = 4;  // offset word within a channel

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [ADC_DW-1:0] sample_t;    // two's complement sample
  typedef logic        [ADC_DW-1:0] dac_word_t;  // unsigned neg-slope pin word

  typedef struct packed {
    logic [SYS_AW-1:0] addr;
    logic [SYS_DW-1:0] wdata;
    logic              wen;   // single cycle write strobe
    logic              ren;   // single cycle read strobe
  } sys_req_t;

  typedef struct packed {
    logic [SYS_DW-1:0] rdata;
    logic              err;
    logic              ack;
  } sys_rsp_t;

  typedef struct packed {
    logic signed [CAL_MW-1:0] mul;  // gain, Q2.14
    logic signed [ADC_DW-1:0] sum;  // offset
  } cal_cfg_t;

  typedef enum logic [REGION_W-1:0] {
    REGION_HK    = 3'd0,
    REGION_CALIB = 3'd1
  } sys_region_e;

endpackage

//--- hw/sys_bus_decoder.sv
////////////////////////////////////////////////////////////////////////////
// system bus decoder
// splits addr[22:20] into regions, answers unmapped ones with an error
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_bus_decoder (
  input  logic             adc_clk,
  input  logic             top_rst,
  // master side
  input  rp_pkg::sys_req_t sys_req_i,
  output rp_pkg::sys_rsp_t sys_rsp_o,
  // housekeeping, region 0
  output rp_pkg::sys_req_t hk_req_o,
  input  rp_pkg::sys_rsp_t hk_rsp_i,
  // calibration, region 1
  output rp_pkg::sys_req_t cal_req_o,
  input  rp_pkg::sys_rsp_t cal_rsp_i
);

  import rp_pkg::*;

  sys_region_e region;
  logic        strobe;
  logic        unmapped;
  logic        err_ack_q;  // ack with err for regions 2..7

  assign region   = sys_region_e'(sys_req_i.addr[REGION_LSB +: REGION_W]);
  assign strobe   = sys_req_i.wen | sys_req_i.ren;
  assign unmapped = (region != REGION_HK) && (region != REGION_CALIB);

  // addr and wdata go everywhere, strobes only to the addressed block
  always_comb
  begin
    hk_req_o      = sys_req_i;
    hk_req_o.wen  = sys_req_i.wen & (region == REGION_HK);
    hk_req_o.ren  = sys_req_i.ren & (region == REGION_HK);
    cal_req_o     = sys_req_i;
    cal_req_o.wen = sys_req_i.wen & (region == REGION_CALIB);
    cal_req_o.ren = sys_req_i.ren & (region == REGION_CALIB);
  end

  always_ff @(posedge adc_clk, posedge top_rst)
  begin
    if (top_rst)
      err_ack_q <= 1'b0;
    else
      err_ack_q <= strobe & unmapped;  // nothing written, read data 0
  end

  // master holds addr until ack, so the current region selects the response
  always_comb
  begin
    case (region)
      REGION_HK:    sys_rsp_o = hk_rsp_i;
      REGION_CALIB: sys_rsp_o = cal_rsp_i;
      default:      sys_rsp_o = '{rdata: '0, err: err_ack_q, ack: err_ack_q};
    endcase
  end

endmodule

//--- rp_analog_top.f
hw/rp_pkg.sv
hw/linear_cal.sv
hw/sys_bus_decoder.sv
hw/hk_regs.sv
hw/calib_regs.sv
hw/adc_frontend.sv
hw/dac_backend.sv
hw/rp_analog_top.sv
testbench/rp_analog_properties.sv
testbench/tb_rp_analog_top.sv

//--- testbench/rp_analog_properties.sv
////////////////////////////////////////////////////////////////////////////
// bus protocol assertions, bound into the system bus decoder
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rp_analog_properties (
  input logic             adc_clk,
  input logic             top_rst,
  input rp_pkg::sys_req_t sys_req_i,
  input rp_pkg::sys_rsp_t sys_rsp_o
);

  int unsigned fail_cnt = 0;  // read by the testbench at the end

  // every strobe answered on the following edge
  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (top_rst)
    (sys_req_i.wen || sys_req_i.ren) |=> sys_rsp_o.ack)
  else
  begin
    $error("strobe not acknowledged on the next cycle");
    fail_cnt++;
  end

  err_with_ack: assert property (@(posedge adc_clk) disable iff (top_rst)
    sys_rsp_o.err |-> sys_rsp_o.ack)
  else
  begin
    $error("err raised without ack");
    fail_cnt++;
  end

  // async reset holds the response quiet
  no_ack_in_reset: assert property (@(posedge adc_clk) top_rst |-> !sys_rsp_o.ack)
  else
  begin
    $error("ack seen while reset is active");
    fail_cnt++;
  end

endmodule

bind sys_bus_decoder rp_analog_properties u_props (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .sys_req_i (sys_req_i),
  .sys_rsp_o (sys_rsp_o)
);

//--- testbench/tb_rp_analog_top.sv
////////////////////////////////////////////////////////////////////////////
// analog top level testbench
// directed bus, conversion, calibration and loopback tests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_rp_analog_top;

  import rp_pkg::*;

  localparam int        BUS_TIMEOUT = 16;  // cycles to wait for ack
  localparam int        NUM_SMP     = 30;  // samples per stream
  localparam int        SMP_MAX     = (1 << (ADC_DW-1)) - 1;
  localparam int        SMP_MIN     = -(1 << (ADC_DW-1));
  localparam dac_word_t LOW_BITS    = dac_word_t'(SMP_MAX);  // bits below the sign

  logic                    adc_clk;
  logic                    top_rst;
  dac_word_t               adc_dat_a;
  dac_word_t               adc_dat_b;
  sample_t   [NUM_CHN-1:0] dac_dat_in;
  sys_req_t                sys_req;
  sys_rsp_t                sys_rsp;
  sample_t   [NUM_CHN-1:0] adc_dat;
  dac_word_t [NUM_CHN-1:0] dac_dat_pin;
  logic      [7:0]         led;

  // calibration as programmed over the bus
  int   adc_gain [NUM_CHN];
  int   adc_ofs  [NUM_CHN];
  int   dac_gain [NUM_CHN];
  int   dac_ofs  [NUM_CHN];
  logic loop_en;

  dac_word_t pin_w [NUM_SMP][NUM_CHN];  // ADC pin stimulus
  sample_t   dac_s [NUM_SMP][NUM_CHN];  // DAC sample stimulus

  int          err_cnt;
  int          check_cnt;
  int unsigned assert_cnt;

  rp_analog_top u_dut (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .dac_dat_i   (dac_dat_in),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .adc_dat_o   (adc_dat),
    .dac_dat_o   (dac_dat_pin),
    .led_o       (led)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;  // 250 MHz
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // pin word to sample: sign kept, low bits flipped
  function automatic int to_sample(dac_word_t w);
    sample_t s;
    s = w ^ LOW_BITS;
    return int'(s);
  endfunction

  function automatic dac_word_t to_pin(int s);
    return s[ADC_DW-1:0] ^ LOW_BITS;
  endfunction

  // x * gain in Q2.14, floor shift, plus offset, clamped
  function automatic int cal_model(int x, int gain, int ofs);
    int r;
    r = ((x * gain) >>> CAL_FRAC) + ofs;
    if (r > SMP_MAX)
      r = SMP_MAX;
    else if (r < SMP_MIN)
      r = SMP_MIN;
    return r;
  endfunction

  function automatic logic [31:0] reg_addr(int region, logic [7:0] ofs);
    return (32'(region) << REGION_LSB) | {24'd0, ofs};
  endfunction

  function automatic logic [31:0] cal_addr(logic dac, int ch, logic is_ofs);
    logic [7:0] ofs;
    ofs = (dac ? CAL_DAC_BASE : CAL_ADC_BASE) + 8'(CAL_CHN_STEP * ch);
    if (is_ofs)
      ofs = ofs + 8'(CAL_SUM_OFS);
    return reg_addr(REGION_CALIB, ofs);
  endfunction

  task automatic compare_word(string name, logic [31:0] got, logic [31:0] exp);
    check_cnt++;
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s got 0x%08h (%0d), expected 0x%08h (%0d)",
               $time, name, got, $signed(got), exp, $signed(exp));
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int wait_cnt;
    @(posedge adc_clk);
    #1;
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.wen   = wr;
    sys_req.ren   = !wr;
    @(posedge adc_clk);
    #1;
    sys_req.wen = 1'b0;  // single cycle strobe, addr held
    sys_req.ren = 1'b0;
    wait_cnt    = 0;
    while (!sys_rsp.ack && wait_cnt < BUS_TIMEOUT)
    begin
      @(posedge adc_clk);
      #1;
      wait_cnt++;
    end
    rdata = sys_rsp.rdata;
    err   = sys_rsp.err;
    if (!sys_rsp.ack)
    begin
      $display("bus access to 0x%08h timed out without ack", addr);
      err_cnt++;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    bus_access(1'b1, addr, data, rd, err);
    if (err)
    begin
      $display("write to 0x%08h returned an unexpected error", addr);
      err_cnt++;
    end
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    logic err;
    bus_access(1'b0, addr, 32'd0, data, err);
    if (err)
    begin
      $display("read from 0x%08h returned an unexpected error", addr);
      err_cnt++;
    end
  endtask

  // program one channel and keep the model in step
  task automatic set_calib(int ch, int ag, int ao, int dg, int dof);
    bus_write(cal_addr(1'b0, ch, 1'b0), 32'(ag));
    bus_write(cal_addr(1'b0, ch, 1'b1), 32'(ao));
    bus_write(cal_addr(1'b1, ch, 1'b0), 32'(dg));
    bus_write(cal_addr(1'b1, ch, 1'b1), 32'(dof));
    adc_gain[ch] = ag;
    adc_ofs[ch]  = ao;
    dac_gain[ch] = dg;
    dac_ofs[ch]  = dof;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // data path streaming
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_stimulus();
    for (int i = 0; i < NUM_SMP; i++)
    begin
      for (int ch = 0; ch < NUM_CHN; ch++)
      begin
        pin_w[i][ch] = dac_word_t'($urandom());
        dac_s[i][ch] = sample_t'($urandom());
      end
    end
    // full scale both ways up front
    pin_w[0] = '{default: 14'h0000};
    pin_w[1] = '{default: 14'h3fff};
    dac_s[0] = '{default: sample_t'(SMP_MAX)};
    dac_s[1] = '{default: sample_t'(SMP_MIN)};
  endtask

  // one new sample per cycle, outputs checked against the model
  task automatic stream_and_check();
    int lat;
    int exp_val;
    lat = loop_en ? 4 : 3;  // loopback skips the pin register
    for (int c = 0; c < NUM_SMP + lat; c++)
    begin
      @(posedge adc_clk);
      #1;
      for (int ch = 0; ch < NUM_CHN; ch++)
      begin
        if (c >= 3 && c - 3 < NUM_SMP)
        begin
          exp_val = cal_model(dac_s[c-3][ch], dac_gain[ch], dac_ofs[ch]);
          compare_word($sformatf("dac_dat_o[%0d]", ch), 32'(dac_dat_pin[ch]),
                       32'(to_pin(exp_val)));
        end
        if (c >= lat)
        begin
          if (loop_en)
            exp_val = cal_model(cal_model(dac_s[c-lat][ch], dac_gain[ch], dac_ofs[ch]),
                                adc_gain[ch], adc_ofs[ch]);
          else
            exp_val = cal_model(to_sample(pin_w[c-lat][ch]), adc_gain[ch], adc_ofs[ch]);
          compare_word($sformatf("adc_dat_o[%0d]", ch), int'(adc_dat[ch]), exp_val);
        end
      end
      if (c < NUM_SMP)
      begin
        adc_dat_a = pin_w[c][0];
        adc_dat_b = pin_w[c][1];
        for (int ch = 0; ch < NUM_CHN; ch++)
          dac_dat_in[ch] = dac_s[c][ch];
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_reset_values();
    logic [31:0] rd;
    bus_read(reg_addr(REGION_HK, HK_ID_OFS), rd);
    compare_word("hk id", rd, 32'h5250_0001);
    bus_read(reg_addr(REGION_HK, HK_LOOP_OFS), rd);
    compare_word("digital loop", rd, 32'd0);
    bus_read(reg_addr(REGION_HK, HK_LED_OFS), rd);
    compare_word("led reg", rd, 32'd0);
    compare_word("led_o", 32'(led), 32'd0);
    for (int ch = 0; ch < NUM_CHN; ch++)
    begin
      for (int d = 0; d < 2; d++)
      begin
        bus_read(cal_addr(d[0], ch, 1'b0), rd);
        compare_word($sformatf("gain dac=%0d ch%0d", d, ch), rd, 32'd16384);
        bus_read(cal_addr(d[0], ch, 1'b1), rd);
        compare_word($sformatf("offset dac=%0d ch%0d", d, ch), rd, 32'd0);
      end
      compare_word($sformatf("dac_dat_o[%0d]", ch), 32'(dac_dat_pin[ch]), 32'(to_pin(0)));
    end
  endtask

  task automatic check_bus_decoding();
    logic [31:0] rd;
    logic        err;
    for (int r = 2; r < 8; r++)
    begin
      bus_access(1'b1, reg_addr(r, HK_LED_OFS), 32'hff, rd, err);
      compare_word($sformatf("write err region %0d", r), 32'(err), 32'd1);
      bus_access(1'b0, reg_addr(r, HK_ID_OFS), 32'd0, rd, err);
      compare_word($sformatf("read err region %0d", r), 32'(err), 32'd1);
      compare_word($sformatf("read data region %0d", r), rd, 32'd0);
    end
    compare_word("led_o", 32'(led), 32'd0);  // erroring writes land nowhere
    bus_write(reg_addr(REGION_HK, HK_LED_OFS), 32'ha5);
    compare_word("led_o", 32'(led), 32'ha5);
    bus_read(reg_addr(REGION_HK, HK_LED_OFS), rd);
    compare_word("led reg", rd, 32'ha5);
  endtask

  task automatic check_adc_unity();
    fill_stimulus();
    stream_and_check();  // gains still at reset value
  endtask

  task automatic check_calibration();
    logic [31:0] rd;
    set_calib(0, 32767, 1000, -12000, -500);
    set_calib(1, -32768, -8192, 24000, 8191);
    bus_read(cal_addr(1'b0, 1, 1'b0), rd);
    compare_word("adc gain ch1", rd, 32'(-32768));  // sign extended
    bus_read(cal_addr(1'b0, 1, 1'b1), rd);
    compare_word("adc offset ch1", rd, 32'(-8192));
    fill_stimulus();
    stream_and_check();
  endtask

  task automatic check_loopback();
    logic [31:0] rd;
    set_calib(0, 20000, -300, 12000, 150);
    bus_write(reg_addr(REGION_HK, HK_LOOP_OFS), 32'd1);
    loop_en = 1'b1;
    bus_read(reg_addr(REGION_HK, HK_LOOP_OFS), rd);
    compare_word("digital loop", rd, 32'd1);
    fill_stimulus();
    stream_and_check();
    bus_write(reg_addr(REGION_HK, HK_LOOP_OFS), 32'd0);
    loop_en = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(10));  // one seed for all random stimulus
    top_rst    = 1'b1;
    adc_dat_a  = '0;
    adc_dat_b  = '0;
    dac_dat_in = '0;
    sys_req    = '0;
    loop_en    = 1'b0;
    err_cnt    = 0;
    check_cnt  = 0;
    for (int ch = 0; ch < NUM_CHN; ch++)
    begin
      adc_gain[ch] = 16384;  // unity
      adc_ofs[ch]  = 0;
      dac_gain[ch] = 16384;
      dac_ofs[ch]  = 0;
    end
    repeat (4) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;

    check_reset_values();
    check_bus_decoding();
    check_adc_unity();
    check_calibration();
    check_loopback();

    assert_cnt = u_dut.u_dec.u_props.fail_cnt;
    $display("checks: %0d  errors: %0d  assertion failures: %0d",
             check_cnt, err_cnt, assert_cnt);
    if (err_cnt == 0 && assert_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule
